// ==== tb.f ====
+incdir+verif
verilog/wb_pkg.sv
verilog/wb_stage.sv
verilog/int_reg_file.sv
verilog/commit_tracker.sv
verilog/wb_subsys.sv
verif/tb_wb_subsys.sv

// ==== Makefile ====
# Verilator build and run for the writeback end testbench.
# Override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := verif/tb_wb_model.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "run: PASS"; \
	else \
	  echo "run: FAIL, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_wb_model.svh ====
// reference model of the writeback end, included inside the testbench module.
// it advances once per clock edge and expects the inputs of that edge.
`ifndef TB_WB_MODEL_SVH
`define TB_WB_MODEL_SVH

  wb_pkg::wb_item_t held_q[$];  // accepted items not yet committed.
  wb_pkg::xlen_t    shadow_regs [wb_pkg::NUM_REGS];
  wb_pkg::xlen_t    exp_instret;
  wb_pkg::xlen_t    exp_skip;
  wb_pkg::xlen_t    exp_last_pc;
  wb_pkg::inst_t    exp_last_inst;
  wb_pkg::intr_no_t exp_last_intr;

  task automatic clear_model();
    held_q.delete();
    for (int i = 0; i < wb_pkg::NUM_REGS; i++) begin
      shadow_regs[i] = '0;
    end
    exp_instret   = '0;
    exp_skip      = '0;
    exp_last_pc   = '0;
    exp_last_inst = '0;
    exp_last_intr = '0;
  endtask

  // one item leaves the stage and is consumed by the tracker and the register file.
  task automatic retire_item(input wb_pkg::wb_item_t it);
    if (!it.nocmt) begin
      exp_instret   = exp_instret + 64'd1;
      exp_last_pc   = it.pc;
      exp_last_inst = it.inst;
      if (it.skipcmt) begin
        exp_skip = exp_skip + 64'd1;
      end
    end
    if (it.intr_no != '0) begin
      exp_last_intr = it.intr_no;  // kept for uncommitted items as well.
    end
    if (it.rd_wen && (it.rd != '0)) begin
      shadow_regs[it.rd] = it.rd_wdata;
    end
  endtask

  // the stage can take an item when it holds none, or when its item leaves now.
  function automatic logic expected_ack(input logic stall);
    return (held_q.size() == 0) || !stall;
  endfunction

  // applies the transfers of the coming edge.
  // the pop runs first, so only items from earlier edges can commit.
  task automatic apply_edge(input logic req, input logic stall, input wb_pkg::wb_item_t in);
    logic             ack;
    wb_pkg::wb_item_t head;
    ack = expected_ack(stall);
    if (!stall && (held_q.size() > 0)) begin
      head = held_q.pop_front();
      retire_item(head);
    end
    if (req && ack) begin
      held_q.push_back(in);
    end
  endtask

`endif

// ==== verif/tb_wb_subsys.sv ====
// random items and a random commit stall drive the writeback end; an included model
// predicts every registered output, and the register file is read back after draining.
`timescale 1ns/1ps

module tb_wb_subsys;

  localparam int ACK_TIMEOUT = 1000;  // cycles an offered item may wait.

  logic             clk;
  logic             rst;
  logic             i_mem_req;
  logic             o_mem_ack;
  wb_pkg::wb_item_t i_mem_item;
  logic             i_commit_stall;
  wb_pkg::ridx_t    i_rs1;
  wb_pkg::ridx_t    i_rs2;
  wb_pkg::xlen_t    o_rs1_data;
  wb_pkg::xlen_t    o_rs2_data;
  wb_pkg::xlen_t    o_instret;
  wb_pkg::xlen_t    o_skip_count;
  wb_pkg::xlen_t    o_last_pc;
  wb_pkg::inst_t    o_last_inst;
  wb_pkg::intr_no_t o_last_intr;

  int               seed;
  int               stall_pct;  // chance in percent of a stalled cycle.
  // running totals of the items the driver has handed over.
  wb_pkg::xlen_t    sent_commits;
  wb_pkg::xlen_t    sent_skips;
  wb_pkg::xlen_t    last_sent_pc;
  wb_pkg::inst_t    last_sent_inst;
  wb_pkg::intr_no_t last_sent_intr;

  `include "tb_wb_model.svh"

  wb_subsys u_wb_subsys (
    .clk            (clk),
    .rst            (rst),
    .i_mem_req      (i_mem_req),
    .o_mem_ack      (o_mem_ack),
    .i_mem_item     (i_mem_item),
    .i_commit_stall (i_commit_stall),
    .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),
    .o_rs1_data     (o_rs1_data),
    .o_rs2_data     (o_rs2_data),
    .o_instret      (o_instret),
    .o_skip_count   (o_skip_count),
    .o_last_pc      (o_last_pc),
    .o_last_inst    (o_last_inst),
    .o_last_intr    (o_last_intr)
  );

  always #5 clk = ~clk;

  task automatic fail_stop();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_xlen(input string name, input wb_pkg::xlen_t exp, input wb_pkg::xlen_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_inst(input string name, input wb_pkg::inst_t exp, input wb_pkg::inst_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_intr(input string name, input wb_pkg::intr_no_t exp,
                            input wb_pkg::intr_no_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      fail_stop();
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // rd leans toward x0, and the flag fields are sparse.
  function automatic wb_pkg::wb_item_t make_item();
    wb_pkg::wb_item_t it;
    it.pc[63:32]      = $random(seed);
    it.pc[31:0]       = $random(seed);
    it.pc[1:0]        = 2'b00;
    it.inst           = $random(seed);
    it.rd             = (rand_below(4) == 0) ? '0 : wb_pkg::ridx_t'(rand_below(wb_pkg::NUM_REGS));
    it.rd_wen         = (rand_below(8) != 0);
    it.rd_wdata[63:32] = $random(seed);
    it.rd_wdata[31:0] = $random(seed);
    it.nocmt          = (rand_below(10) == 0);
    it.skipcmt        = (rand_below(8) == 0);
    it.intr_no        = (rand_below(12) == 0) ? ($random(seed) | 32'h1) : '0;
    return it;
  endfunction

  // every input change happens 1 ns after a rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
    i_commit_stall = (rand_below(100) < stall_pct);
  endtask

  task automatic note_sent(input wb_pkg::wb_item_t it);
    if (!it.nocmt) begin
      sent_commits   = sent_commits + 64'd1;
      last_sent_pc   = it.pc;
      last_sent_inst = it.inst;
      if (it.skipcmt) begin
        sent_skips = sent_skips + 64'd1;
      end
    end
    if (it.intr_no != '0) begin
      last_sent_intr = it.intr_no;
    end
  endtask

  // holds the item until ack is seen at a negedge, where the handshake is settled.
  task automatic send_item(input wb_pkg::wb_item_t it);
    int waited;
    waited     = 0;
    i_mem_req  = 1'b1;
    i_mem_item = it;
    @(negedge clk);
    while (!o_mem_ack) begin
      waited++;
      if (waited > ACK_TIMEOUT) begin
        $display("ERROR: o_mem_ack stayed low for %0d cycles with an item offered", waited);
        fail_stop();
      end
      next_cycle();
      @(negedge clk);
    end
    note_sent(it);
    next_cycle();
    i_mem_req = 1'b0;
  endtask

  // a held item commits at the first edge that sees the stall low.
  task automatic drain_stage();
    stall_pct = 0;
    next_cycle();
    next_cycle();
    @(negedge clk);
  endtask

  task automatic run_phase(input int count, input int pct);
    int gap;
    stall_pct = pct;
    next_cycle();
    for (int n = 0; n < count; n++) begin
      send_item(make_item());
      gap = (rand_below(3) == 0) ? rand_below(4) : 0;  // mostly back to back.
      for (int g = 0; g < gap; g++) begin
        next_cycle();
      end
    end
    drain_stage();
  endtask

  task automatic verify_totals(input string name);
    check_flag({name, " mem_ack"}, 1'b1, o_mem_ack);
    check_xlen({name, " instret"}, sent_commits, o_instret);
    check_xlen({name, " skip_count"}, sent_skips, o_skip_count);
    check_xlen({name, " last_pc"}, last_sent_pc, o_last_pc);
    check_inst({name, " last_inst"}, last_sent_inst, o_last_inst);
    check_intr({name, " last_intr"}, last_sent_intr, o_last_intr);
  endtask

  // rs2 walks the indices downward so both ports see every register.
  task automatic compare_regs(input string name, input logic expect_zero);
    wb_pkg::xlen_t exp1;
    wb_pkg::xlen_t exp2;
    int            j;
    for (int i = 0; i < wb_pkg::NUM_REGS; i++) begin
      j = wb_pkg::NUM_REGS - 1 - i;
      next_cycle();
      i_rs1 = wb_pkg::ridx_t'(i);
      i_rs2 = wb_pkg::ridx_t'(j);
      exp1  = expect_zero ? '0 : shadow_regs[i];
      exp2  = expect_zero ? '0 : shadow_regs[j];
      @(negedge clk);
      check_xlen($sformatf("%s rs1 x%0d", name, i), exp1, o_rs1_data);
      check_xlen($sformatf("%s rs2 x%0d", name, j), exp2, o_rs2_data);
    end
  endtask

  // registered outputs are compared against the model once per cycle.
  always @(negedge clk) begin
    if (rst) begin
      clear_model();
    end else begin
      check_flag("cycle mem_ack", expected_ack(i_commit_stall), o_mem_ack);
      check_xlen("cycle instret", exp_instret, o_instret);
      check_xlen("cycle skip_count", exp_skip, o_skip_count);
      check_xlen("cycle last_pc", exp_last_pc, o_last_pc);
      check_inst("cycle last_inst", exp_last_inst, o_last_inst);
      check_intr("cycle last_intr", exp_last_intr, o_last_intr);
      apply_edge(i_mem_req, i_commit_stall, i_mem_item);
    end
  end

  initial begin
    seed           = 32'hb24a;
    rst            = 1'b1;
    clk            = 1'b0;
    i_mem_req      = 1'b0;
    i_mem_item     = '0;
    i_commit_stall = 1'b0;
    i_rs1          = '0;
    i_rs2          = '0;
    stall_pct      = 0;
    sent_commits   = '0;
    sent_skips     = '0;
    last_sent_pc   = '0;
    last_sent_inst = '0;
    last_sent_intr = '0;
    clear_model();

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    verify_totals("reset");
    compare_regs("reset", 1'b1);

    run_phase(80, 0);
    verify_totals("no stall");

    run_phase(200, 40);  // stalls leave the stage full with ack low.
    verify_totals("random stall");
    compare_regs("final", 1'b0);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verilog/wb_subsys.sv ====
// writeback end: holding stage feeding the commit tracker and the register file.
// an input transfer commits one edge later at the earliest, later under stall.
`timescale 1ns/1ps

module wb_subsys (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_mem_req,
  output logic             o_mem_ack,
  input  wb_pkg::wb_item_t i_mem_item,
  input  logic             i_commit_stall,
  input  wb_pkg::ridx_t    i_rs1,
  input  wb_pkg::ridx_t    i_rs2,
  output wb_pkg::xlen_t    o_rs1_data,
  output wb_pkg::xlen_t    o_rs2_data,
  output wb_pkg::xlen_t    o_instret,
  output wb_pkg::xlen_t    o_skip_count,
  output wb_pkg::xlen_t    o_last_pc,
  output wb_pkg::inst_t    o_last_inst,
  output wb_pkg::intr_no_t o_last_intr
);

  logic             wb_req;
  logic             wb_ack;
  wb_pkg::wb_item_t wb_item;
  logic             rf_wen;

  wb_stage u_wb_stage (
    .clk        (clk),
    .rst        (rst),
    .i_mem_req  (i_mem_req),
    .o_mem_ack  (o_mem_ack),
    .i_mem_item (i_mem_item),
    .o_wb_req   (wb_req),
    .i_wb_ack   (wb_ack),
    .o_wb_item  (wb_item)
  );

  commit_tracker u_commit_tracker (
    .clk          (clk),
    .rst          (rst),
    .i_stall      (i_commit_stall),
    .i_wb_req     (wb_req),
    .o_wb_ack     (wb_ack),
    .i_wb_item    (wb_item),
    .o_instret    (o_instret),
    .o_skip_count (o_skip_count),
    .o_last_pc    (o_last_pc),
    .o_last_inst  (o_last_inst),
    .o_last_intr  (o_last_intr)
  );

  // the register file writes on the same transfer the tracker consumes.
  assign rf_wen = wb_req & wb_ack & wb_item.rd_wen;

  int_reg_file u_int_reg_file (
    .clk      (clk),
    .rst      (rst),
    .i_wen    (rf_wen),
    .i_waddr  (wb_item.rd),
    .i_wdata  (wb_item.rd_wdata),
    .i_raddr1 (i_rs1),
    .i_raddr2 (i_rs2),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

// ==== verilog/commit_tracker.sv ====
// consumer of writeback items that keeps retire counters and last-commit records.
// all outputs are registered and show a commit one cycle after its transfer.
`timescale 1ns/1ps

module commit_tracker (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_stall,
  input  logic             i_wb_req,
  output logic             o_wb_ack,
  input  wb_pkg::wb_item_t i_wb_item,
  output wb_pkg::xlen_t    o_instret,
  output wb_pkg::xlen_t    o_skip_count,
  output wb_pkg::xlen_t    o_last_pc,
  output wb_pkg::inst_t    o_last_inst,
  output wb_pkg::intr_no_t o_last_intr
);

  logic             xfer;
  logic             commit;  // transfer of an item that counts as a commit.
  wb_pkg::xlen_t    instret_q;
  wb_pkg::xlen_t    skip_q;
  wb_pkg::xlen_t    last_pc_q;
  wb_pkg::inst_t    last_inst_q;
  wb_pkg::intr_no_t last_intr_q;

  assign o_wb_ack = ~i_stall;  // stall alone holds items back.
  assign xfer     = i_wb_req & o_wb_ack;
  assign commit   = xfer & ~i_wb_item.nocmt;

  // retire counters.
  always_ff @(posedge clk) begin
    if (rst) begin
      instret_q <= '0;
      skip_q    <= '0;
    end else begin
      if (commit) begin
        instret_q <= instret_q + 1'b1;
      end
      if (commit && i_wb_item.skipcmt) begin
        skip_q <= skip_q + 1'b1;  // only committed items can be skipped.
      end
    end
  end

  // last-commit records.
  always_ff @(posedge clk) begin
    if (rst) begin
      last_pc_q   <= '0;
      last_inst_q <= '0;
      last_intr_q <= '0;
    end else begin
      if (commit) begin
        last_pc_q   <= i_wb_item.pc;
        last_inst_q <= i_wb_item.inst;
      end
      // the interrupt number is kept even when the item itself is not committed.
      if (xfer && (i_wb_item.intr_no != '0)) begin
        last_intr_q <= i_wb_item.intr_no;
      end
    end
  end

  assign o_instret    = instret_q;
  assign o_skip_count = skip_q;
  assign o_last_pc    = last_pc_q;
  assign o_last_inst  = last_inst_q;
  assign o_last_intr  = last_intr_q;

endmodule

// ==== verilog/int_reg_file.sv ====
// integer register file with one write port and two combinational read ports.
// reads do not bypass a write in the same cycle; x0 ignores writes.
`timescale 1ns/1ps

module int_reg_file (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_wen,
  input  wb_pkg::ridx_t i_waddr,
  input  wb_pkg::xlen_t i_wdata,
  input  wb_pkg::ridx_t i_raddr1,
  input  wb_pkg::ridx_t i_raddr2,
  output wb_pkg::xlen_t o_rdata1,
  output wb_pkg::xlen_t o_rdata2
);

  wb_pkg::xlen_t regs [wb_pkg::NUM_REGS];
  logic          wr_ok;

  // index zero is hardwired, so its entry keeps the reset value.
  assign wr_ok = i_wen & (i_waddr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < wb_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];  // sees the old value during a write cycle.

endmodule

// ==== verilog/wb_stage.sv ====
// one-entry holding register between memory and writeback, req/ack on both sides.
// the input is acked only when the entry is free or leaves in the same cycle.
`timescale 1ns/1ps

module wb_stage (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_mem_req,
  output logic             o_mem_ack,
  input  wb_pkg::wb_item_t i_mem_item,
  output logic             o_wb_req,
  input  logic             i_wb_ack,
  output wb_pkg::wb_item_t o_wb_item
);

  logic             full;      // an item is held and offered downstream.
  wb_pkg::wb_item_t item_q;
  logic             mem_xfer;
  logic             wb_xfer;

  // the held item leaves this cycle.
  assign wb_xfer = o_wb_req & i_wb_ack;

  // room exists when empty, or when the current item drains in the same cycle.
  // this keeps one item per cycle without ever overwriting a held item.
  assign o_mem_ack = ~full | wb_xfer;
  assign mem_xfer  = i_mem_req & o_mem_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (mem_xfer) begin
      full <= 1'b1;  // a load wins over a drain in the same cycle.
    end else if (wb_xfer) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_xfer) begin
      item_q <= i_mem_item;
    end
  end

  assign o_wb_req = full;

  // downstream sees zeros while nothing is held.
  assign o_wb_item = full ? item_q : '0;

endmodule

// ==== verilog/wb_pkg.sv ====
// widths, vector types and the retiring-instruction record shared by the writeback end.
// the record is packed, so field order fixes its bit layout on every link.
package wb_pkg;

  // data, program counter and counter width.
  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;  // integer register count, x0 included.

  // one machine word, used for pc, register data and the retire counters.
  typedef logic [XLEN-1:0] xlen_t;

  typedef logic [31:0] inst_t;  // raw 32-bit instruction encoding.

  // index into the integer register file.
  typedef logic [$clog2(NUM_REGS)-1:0] ridx_t;

  typedef logic [31:0] intr_no_t;  // zero means no interrupt came with the item.

  // one retired instruction as it leaves the memory stage.
  // nocmt marks an item that retires without counting as a commit.
  // skipcmt marks a commit whose result a reference model copies rather than checks.
  typedef struct packed {
    xlen_t    pc;
    inst_t    inst;
    ridx_t    rd;
    logic     rd_wen;    // rd_wdata goes to rd when set.
    xlen_t    rd_wdata;
    logic     nocmt;
    logic     skipcmt;
    intr_no_t intr_no;
  } wb_item_t;

endpackage
